// ==== parser_pkg.sv ====
`default_nettype none

package parser_pkg;

    // Packet ID width sets where the tagger ID wraps
    localparam int PKT_AWIDTH = 16;

    // Header constants compared against the first flit
    localparam logic [15:0] PROT_ETH = 16'h0800;
    localparam logic [3:0]  IP_V4    = 4'd4;
    localparam logic [7:0]  PROT_TCP = 8'd6;
    localparam logic [7:0]  PROT_UDP = 8'd17;

    // One beat of the 512-bit stream
    // Ethernet header sits at the high end of data
    typedef struct packed {
        logic [511:0] data;
        logic         sop;
        logic         eop;
        logic [5:0]   empty;
    } pkt_flit_t;

    // Frame class
    typedef enum logic [1:0] {
        NS,
        S_TCP,
        S_UDP
    } prot_t;

    // Where the record is headed downstream
    typedef enum logic {
        PKT_ETH,
        PKT_PCIE
    } pkt_dest_t;

    // Flow 5-tuple without the protocol byte
    typedef struct packed {
        logic [31:0] sIP;
        logic [31:0] dIP;
        logic [15:0] sPort;
        logic [15:0] dPort;
    } tuple_t;

    // Per-frame record out of the parser
    // The tagger fills only pktID and flits
    typedef struct packed {
        logic [PKT_AWIDTH-1:0] pktID;
        logic [7:0]            flits;
        logic [15:0]           len;
        tuple_t                tuple;
        prot_t                 prot;
        logic [8:0]            tcp_flags;
        pkt_dest_t             pkt_flags;
    } metadata_t;

    // Running totals kept by the consumer
    typedef struct packed {
        logic [31:0] tcp_cnt;
        logic [31:0] udp_cnt;
        logic [31:0] ns_cnt;
        logic [31:0] payload_bytes;
    } stats_t;

endpackage

`default_nettype wire

// ==== pkt_tagger.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_tagger (
    input  logic                  clk,
    input  logic                  rst,
    input  parser_pkg::pkt_flit_t in_flit,
    input  logic                  in_valid,
    output logic                  in_ready,
    output parser_pkg::pkt_flit_t hdr_flit,
    output parser_pkg::metadata_t hdr_tag,
    output logic                  hdr_valid,
    input  logic                  hdr_ready
);

    import parser_pkg::*;

    logic                  accept;
    logic                  last;
    logic [7:0]            flit_cnt;
    logic [7:0]            cnt_next;
    logic [PKT_AWIDTH-1:0] pkt_id;
    pkt_flit_t             first_flit;
    pkt_flit_t             head_sel;

    // Stall the stream only while a header waits downstream
    assign in_ready = ~hdr_valid | hdr_ready;
    assign accept   = in_valid & in_ready;
    assign last     = accept & in_flit.eop;

    // A one-flit frame is its own header
    assign cnt_next = in_flit.sop ? 8'd1 : flit_cnt + 8'd1;
    assign head_sel = in_flit.sop ? in_flit : first_flit;

    // Header flit and tag registers
    always_ff @(posedge clk) begin
        if (accept && in_flit.sop) begin
            first_flit <= in_flit;
        end
        if (last) begin
            hdr_flit       <= head_sel;
            hdr_flit.sop   <= 1'b1;
            hdr_flit.eop   <= 1'b1;
            hdr_tag        <= '0;
            hdr_tag.pktID  <= pkt_id;
            hdr_tag.flits  <= cnt_next;
        end
    end

    // Flit counter, packet ID and output valid
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid <= 1'b0;
            pkt_id    <= '0;
            flit_cnt  <= '0;
        end else begin
            if (accept) begin
                flit_cnt <= in_flit.eop ? 8'd0 : cnt_next;
            end
            if (last) begin
                hdr_valid <= 1'b1;
                pkt_id    <= pkt_id + 1'b1;
            end else if (hdr_ready) begin
                hdr_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== parser.sv ====
`timescale 1ns/100ps
`default_nettype none

module parser (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  disable_pcie,
    input  parser_pkg::pkt_flit_t hdr_flit,
    input  parser_pkg::metadata_t hdr_tag,
    input  logic                  hdr_valid,
    output logic                  hdr_ready,
    output parser_pkg::metadata_t meta,
    output logic                  meta_valid,
    input  logic                  meta_ready
);

    import parser_pkg::*;

    // Ethernet and IPv4 fields
    logic [15:0] eth_type;
    logic [3:0]  ip_version;
    logic [3:0]  ip_ihl;
    logic [15:0] ip_len;
    logic [7:0]  ip_prot;
    logic [31:0] ip_sip;
    logic [15:0] ip_dip_high;
    logic [15:0] ip_dip_low;

    // Transport fields at the same port offsets for TCP and UDP
    logic [15:0] l4_sport;
    logic [15:0] l4_dport;
    logic [3:0]  tcp_do;
    logic [8:0]  tcp_flags;

    logic [15:0] ip_hdr_bytes;
    logic [15:0] l4_hdr_bytes;
    logic        is_tcp;
    logic        is_udp;
    logic        support;
    logic        take;
    metadata_t   meta_next;

    // Big-endian data in 128-bit lanes numbered from the bottom
    assign eth_type    = hdr_flit.data[128*3+31:128*3+16];
    assign ip_version  = hdr_flit.data[128*3+15:128*3+12];
    assign ip_ihl      = hdr_flit.data[128*3+11:128*3+8];

    assign ip_len      = hdr_flit.data[128*2+127:128*2+112];
    assign ip_prot     = hdr_flit.data[128*2+71:128*2+64];
    assign ip_sip      = hdr_flit.data[128*2+47:128*2+16];
    assign ip_dip_high = hdr_flit.data[128*2+15:128*2+0];

    assign ip_dip_low  = hdr_flit.data[128+127:128+112];
    assign l4_sport    = hdr_flit.data[128+111:128+96];
    assign l4_dport    = hdr_flit.data[128+95:128+80];
    assign tcp_do      = hdr_flit.data[128+15:128+12];
    // NS, CWR, ECE, URG, ACK, PSH, RST, SYN, FIN from high to low
    assign tcp_flags   = hdr_flit.data[128+8:128+0];

    // Only the basic 20-byte IPv4 header is understood
    assign is_tcp  = (ip_prot == PROT_TCP);
    assign is_udp  = (ip_prot == PROT_UDP);
    assign support = (eth_type == PROT_ETH) && (ip_version == IP_V4)
                   && (ip_ihl == 4'd5) && (is_tcp || is_udp);

    // Header sizes in bytes with the UDP header fixed at 8
    assign ip_hdr_bytes = {10'd0, ip_ihl, 2'b00};
    assign l4_hdr_bytes = is_tcp ? {10'd0, tcp_do, 2'b00} : 16'd8;

    always_comb begin
        meta_next.pktID       = hdr_tag.pktID;
        meta_next.flits       = hdr_tag.flits;
        meta_next.len         = ip_len - ip_hdr_bytes - l4_hdr_bytes;
        meta_next.tuple.sIP   = ip_sip;
        meta_next.tuple.dIP   = {ip_dip_high, ip_dip_low};
        meta_next.tuple.sPort = l4_sport;
        meta_next.tuple.dPort = l4_dport;
        meta_next.tcp_flags   = tcp_flags;
        meta_next.pkt_flags   = disable_pcie ? PKT_ETH : PKT_PCIE;
        if (!support) begin
            meta_next.prot = NS;
        end else if (is_tcp) begin
            meta_next.prot = S_TCP;
        end else begin
            meta_next.prot = S_UDP;
        end
    end

    // Single output register that refills while it drains
    assign hdr_ready = ~meta_valid | meta_ready;
    assign take      = hdr_valid & hdr_ready;

    always_ff @(posedge clk) begin
        if (take) begin
            meta <= meta_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            meta_valid <= 1'b0;
        end else if (hdr_ready) begin
            meta_valid <= hdr_valid;
        end
    end

endmodule

`default_nettype wire

// ==== meta_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module meta_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  parser_pkg::metadata_t wr_data,
    input  logic                  wr_valid,
    output logic                  wr_ready,
    output parser_pkg::metadata_t rd_data,
    output logic                  rd_valid,
    input  logic                  rd_ready
);

    import parser_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    metadata_t       mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_wr;
    logic            do_rd;

    assign wr_ready = (count != CW'(DEPTH));
    assign rd_valid = (count != '0);
    // Head entry shows without a read request
    assign rd_data  = mem[rd_ptr];

    assign do_wr = wr_valid & wr_ready;
    assign do_rd = rd_valid & rd_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap at DEPTH even when it is not a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== flow_stats.sv ====
`timescale 1ns/100ps
`default_nettype none

module flow_stats (
    input  logic                  clk,
    input  logic                  rst,
    input  parser_pkg::metadata_t in_meta,
    input  logic                  in_valid,
    output logic                  in_ready,
    output parser_pkg::metadata_t out_meta,
    output logic                  out_valid,
    input  logic                  out_ready,
    output parser_pkg::stats_t    stats
);

    import parser_pkg::*;

    logic        xfer;
    logic [31:0] len_ext;

    // Records flow through untouched
    assign out_meta  = in_meta;
    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    assign xfer    = in_valid & out_ready;
    assign len_ext = {16'd0, in_meta.len};

    // Count each record as it leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            stats <= '0;
        end else if (xfer) begin
            case (in_meta.prot)
                S_TCP: begin
                    stats.tcp_cnt       <= stats.tcp_cnt + 32'd1;
                    stats.payload_bytes <= stats.payload_bytes + len_ext;
                end
                S_UDP: begin
                    stats.udp_cnt       <= stats.udp_cnt + 32'd1;
                    stats.payload_bytes <= stats.payload_bytes + len_ext;
                end
                default: begin
                    // Length of an unsupported frame is meaningless
                    stats.ns_cnt <= stats.ns_cnt + 32'd1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== parser_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module parser_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  disable_pcie,
    input  parser_pkg::pkt_flit_t in_flit,
    input  logic                  in_valid,
    output logic                  in_ready,
    output parser_pkg::metadata_t out_meta,
    output logic                  out_valid,
    input  logic                  out_ready,
    output parser_pkg::stats_t    stats
);

    import parser_pkg::*;

    // Tagger to parser
    pkt_flit_t tag_flit;
    metadata_t tag_meta;
    logic      tag_valid;
    logic      tag_ready;

    // Parser to FIFO
    metadata_t par_meta;
    logic      par_valid;
    logic      par_ready;

    // FIFO to statistics
    metadata_t fifo_meta;
    logic      fifo_valid;
    logic      fifo_ready;

    pkt_tagger u_tagger (
        .clk       (clk),
        .rst       (rst),
        .in_flit   (in_flit),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .hdr_flit  (tag_flit),
        .hdr_tag   (tag_meta),
        .hdr_valid (tag_valid),
        .hdr_ready (tag_ready)
    );

    parser u_parser (
        .clk          (clk),
        .rst          (rst),
        .disable_pcie (disable_pcie),
        .hdr_flit     (tag_flit),
        .hdr_tag      (tag_meta),
        .hdr_valid    (tag_valid),
        .hdr_ready    (tag_ready),
        .meta         (par_meta),
        .meta_valid   (par_valid),
        .meta_ready   (par_ready)
    );

    meta_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (par_meta),
        .wr_valid (par_valid),
        .wr_ready (par_ready),
        .rd_data  (fifo_meta),
        .rd_valid (fifo_valid),
        .rd_ready (fifo_ready)
    );

    flow_stats u_stats (
        .clk       (clk),
        .rst       (rst),
        .in_meta   (fifo_meta),
        .in_valid  (fifo_valid),
        .in_ready  (fifo_ready),
        .out_meta  (out_meta),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .stats     (stats)
    );

endmodule

`default_nettype wire

// ==== tb_parser_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_parser_top;

    import parser_pkg::*;

    localparam int N_FRAMES = 300;
    localparam int N_PHASES = 3;
    localparam int TIMEOUT  = N_FRAMES * 4 * 4 + 200;

    logic      clk;
    logic      rst;
    logic      disable_pcie;
    pkt_flit_t in_flit;
    logic      in_valid;
    logic      in_ready;
    metadata_t out_meta;
    logic      out_valid;
    logic      out_ready;
    stats_t    stats;

    logic [31:0]           lfsr;
    int                    cycles = 0;
    logic [511:0]          hdr_data;
    int                    n_flits;
    metadata_t             cur_exp;
    metadata_t             exp_q[$];
    logic [PKT_AWIDTH-1:0] next_id;
    stats_t                model;

    parser_top #(
        .FIFO_DEPTH (8)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .disable_pcie (disable_pcie),
        .in_flit      (in_flit),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_meta     (out_meta),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .stats        (stats)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // Top bit of a frame byte with byte 0 at the high end
    function automatic int field_hi(input int byte_off);
        return 511 - 8 * byte_off;
    endfunction

    task automatic fail_stop();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic compare_meta(input string name, input metadata_t exp, input metadata_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            fail_stop();
        end
    endtask

    task automatic compare_stats(input string name, input stats_t exp, input stats_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            fail_stop();
        end
    endtask

    // Random header flit plus the record it should produce
    task automatic build_frame();
        logic [31:0] r;
        logic [15:0] eth;
        logic [3:0]  ver;
        logic [3:0]  ihl;
        logic [7:0]  proto;
        logic [15:0] ip_len;
        logic [3:0]  data_off;
        for (int w = 0; w < 16; w++) begin
            draw(32, r);
            hdr_data[w*32 +: 32] = r;
        end
        draw(3, r);
        eth = PROT_ETH;
        if (r[2:0] == 3'd0) begin
            draw(16, r);
            eth = r[15:0];
        end
        draw(3, r);
        ver = IP_V4;
        if (r[2:0] == 3'd0) begin
            draw(4, r);
            ver = r[3:0];
        end
        draw(3, r);
        ihl = 4'd5;
        if (r[2:0] == 3'd0) begin
            draw(4, r);
            ihl = r[3:0];
        end
        draw(2, r);
        case (r[1:0])
            2'd2: proto = PROT_UDP;
            2'd3: begin
                draw(8, r);
                proto = r[7:0];
            end
            default: proto = PROT_TCP;
        endcase
        draw(16, r);
        ip_len = r[15:0];
        hdr_data[field_hi(12) -: 16] = eth;
        hdr_data[field_hi(14) -: 8]  = {ver, ihl};
        hdr_data[field_hi(16) -: 16] = ip_len;
        hdr_data[field_hi(23) -: 8]  = proto;
        draw(32, r);
        cur_exp.tuple.sIP = r;
        hdr_data[field_hi(26) -: 32] = r;
        draw(32, r);
        cur_exp.tuple.dIP = r;
        hdr_data[field_hi(30) -: 32] = r;
        draw(16, r);
        cur_exp.tuple.sPort = r[15:0];
        hdr_data[field_hi(34) -: 16] = r[15:0];
        draw(16, r);
        cur_exp.tuple.dPort = r[15:0];
        hdr_data[field_hi(36) -: 16] = r[15:0];
        draw(4, r);
        data_off = r[3:0];
        draw(9, r);
        cur_exp.tcp_flags = r[8:0];
        // Data offset, three reserved bits, then the nine flag bits
        hdr_data[field_hi(46) -: 16] = {data_off, 3'b000, r[8:0]};

        cur_exp.len = ip_len - 16'(ihl) * 16'd4;
        if (proto == PROT_TCP) begin
            cur_exp.len = cur_exp.len - 16'(data_off) * 16'd4;
        end else begin
            cur_exp.len = cur_exp.len - 16'd8;
        end
        if (eth != PROT_ETH || ver != IP_V4 || ihl != 4'd5) begin
            cur_exp.prot = NS;
        end else if (proto == PROT_TCP) begin
            cur_exp.prot = S_TCP;
        end else if (proto == PROT_UDP) begin
            cur_exp.prot = S_UDP;
        end else begin
            cur_exp.prot = NS;
        end
        draw(2, r);
        n_flits = r[1:0] + 1;
        cur_exp.flits = 8'(n_flits);
    endtask

    task automatic drive_flit(input int idx);
        logic [31:0] r;
        in_flit.sop = (idx == 0);
        in_flit.eop = (idx == n_flits - 1);
        if (idx == 0) begin
            in_flit.data = hdr_data;
        end else begin
            draw(32, r);
            in_flit.data = {16{r}};
        end
        draw(6, r);
        in_flit.empty = in_flit.eop ? r[5:0] : 6'd0;
        in_valid = 1'b1;
    endtask

    // Record is owed once the frame is fully accepted
    task automatic push_expected();
        cur_exp.pktID     = next_id;
        cur_exp.pkt_flags = disable_pcie ? PKT_ETH : PKT_PCIE;
        exp_q.push_back(cur_exp);
        next_id = next_id + 1'b1;
        case (cur_exp.prot)
            S_TCP: begin
                model.tcp_cnt       = model.tcp_cnt + 32'd1;
                model.payload_bytes = model.payload_bytes + 32'(cur_exp.len);
            end
            S_UDP: begin
                model.udp_cnt       = model.udp_cnt + 32'd1;
                model.payload_bytes = model.payload_bytes + 32'(cur_exp.len);
            end
            default: model.ns_cnt = model.ns_cnt + 32'd1;
        endcase
    endtask

    task automatic check_output();
        metadata_t exp;
        if (exp_q.size() == 0) begin
            $display("Record with pktID %0d came out with no frame outstanding",
                     out_meta.pktID);
            fail_stop();
        end else begin
            exp = exp_q.pop_front();
            compare_meta($sformatf("frame %0d", exp.pktID), exp, out_meta);
        end
    endtask

    // Each pass handles one falling edge on both sides of the DUT
    task automatic run_phase(input int n_frames);
        int          sent;
        int          idx;
        logic        in_fire;
        logic [31:0] r;
        sent    = 0;
        idx     = 0;
        in_fire = 1'b0;
        while (sent < n_frames || exp_q.size() != 0) begin
            @(negedge clk);
            if (in_fire) begin
                if (in_flit.eop) begin
                    push_expected();
                    sent = sent + 1;
                    idx  = 0;
                end else begin
                    idx = idx + 1;
                end
                in_valid = 1'b0;
            end
            draw(2, r);
            out_ready = (r[1:0] != 2'd0);
            if (out_valid && out_ready) begin
                check_output();
            end
            if (!in_valid && sent < n_frames) begin
                draw(2, r);
                if (r[1:0] != 2'd0) begin
                    if (idx == 0) begin
                        build_frame();
                    end
                    drive_flit(idx);
                end
            end
            in_fire = in_valid && in_ready;
        end
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, %0d records still owed", cycles, exp_q.size());
            fail_stop();
        end
    end

    initial begin
        lfsr         = 32'h2e87;
        rst          = 1'b1;
        disable_pcie = 1'b0;
        in_flit      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        next_id      = '0;
        model        = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Destination flag flips only while nothing is in flight
        for (int p = 0; p < N_PHASES; p++) begin
            disable_pcie = p[0];
            run_phase(N_FRAMES / N_PHASES);
        end
        out_ready = 1'b0;
        @(negedge clk);
        if (out_valid) begin
            $display("Extra record on the output after all frames were matched");
            fail_stop();
        end else begin
            compare_stats("final stats", model, stats);
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
parser_pkg.sv
pkt_tagger.sv
parser.sv
meta_fifo.sv
flow_stats.sv
parser_top.sv
tb_parser_top.sv
